// ==== radio_pkg.sv ====
////////////////////
// Shared types for the radio control plane: settings addresses,
// readback selects, decoder states and the bus structs.
// Modules take it in by a wildcard import in their header.
////////////////////

package radio_pkg;

   // Complex sample, I in the upper half and Q in the lower half
   localparam int SAMPLE_W = 32;

   // Free-running time counter width
   localparam int TIME_W = 64;

   ////////////////////
   // Settings bus addresses

   typedef enum logic [7:0] {
      SR_LOOPBACK   = 8'd6,
      SR_TEST       = 8'd21,
      SR_CODEC_IDLE = 8'd22,
      SR_READBACK   = 8'd32,
      SR_TIME_HI    = 8'd128,
      SR_TIME_LO    = 8'd129
   } sr_addr_e;

   ////////////////////
   // Readback selects, anything else reads zero

   typedef enum logic [2:0] {
      RB_TEST     = 3'd0,
      RB_TIME     = 3'd1,
      RB_FRONTEND = 3'd3
   } rb_sel_e;

   // Command decoder FSM
   typedef enum logic [1:0] {
      ST_HEADER,
      ST_PAYLOAD,
      ST_ISSUE,
      ST_WAIT_RESP
   } dec_state_e;

   ////////////////////
   // Bus structs

   // One beat of a control or response packet
   typedef struct packed {
      logic [63:0] tdata;
      logic        tlast;   // Last beat of the packet
   } stream_beat_t;

   // Settings bus write
   typedef struct packed {
      logic        stb;     // One cycle per write
      sr_addr_e    addr;
      logic [31:0] data;
   } set_bus_t;

endpackage

// ==== ctrl_decoder.sv ====
////////////////////
// Control packet decoder. Takes two-beat packets (header, then
// address/data payload) and issues one settings-bus write each.
// Holds off the next packet until its response has gone out.
////////////////////

`timescale 1ns/1ns

module ctrl_decoder
   import radio_pkg::*;
(
   input  logic         bus_clk,
   input  logic         i_reset,
   input  stream_beat_t i_ctrl,
   input  logic         i_ctrl_tvalid,
   output logic         o_ctrl_tready,
   output set_bus_t     o_set,
   output logic [63:0]  o_header,
   output logic         o_issue,
   input  logic         i_resp_done
);

   dec_state_e  state;
   logic [63:0] header_r;
   logic [63:0] payload_r;
   logic        ctrl_xfer;

   assign o_ctrl_tready = (state == ST_HEADER) || (state == ST_PAYLOAD);
   assign ctrl_xfer     = i_ctrl_tvalid && o_ctrl_tready;

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         state <= ST_HEADER;
      end else begin
         case (state)
            ST_HEADER: begin
               // A lone beat with tlast is not a command, drop it
               if (ctrl_xfer && !i_ctrl.tlast)
                  state <= ST_PAYLOAD;
            end
            ST_PAYLOAD: begin
               if (ctrl_xfer)
                  state <= ST_ISSUE;
            end
            ST_ISSUE:     state <= ST_WAIT_RESP;  // Strobe lasts this one cycle
            ST_WAIT_RESP: if (i_resp_done) state <= ST_HEADER;
            default:      state <= ST_HEADER;
         endcase
      end
   end

   // Header and payload capture
   always_ff @(posedge bus_clk) begin
      if (ctrl_xfer && (state == ST_HEADER))
         header_r <= i_ctrl.tdata;
      if (ctrl_xfer && (state == ST_PAYLOAD))
         payload_r <= i_ctrl.tdata;
   end

   assign o_set.stb  = (state == ST_ISSUE);
   assign o_set.addr = sr_addr_e'(payload_r[39:32]);  // Address byte
   assign o_set.data = payload_r[31:0];
   assign o_issue    = (state == ST_ISSUE);
   assign o_header   = header_r;

endmodule

// ==== radio_settings.sv ====
////////////////////
// Setting registers written from the settings bus, the loadable
// time counter, and the TX/RX front-end registers with loopback.
////////////////////

`timescale 1ns/1ns

module radio_settings
   import radio_pkg::*;
#(
   parameter logic [SAMPLE_W-1:0] IDLE_DEFAULT = '0
) (
   input  logic                bus_clk,
   input  logic                i_reset,
   input  set_bus_t            i_set,
   input  logic [SAMPLE_W-1:0] i_rx,
   input  logic                i_tx_run,
   input  logic [SAMPLE_W-1:0] i_tx_sample,
   output logic [SAMPLE_W-1:0] o_tx,
   output logic [SAMPLE_W-1:0] o_rx_fe,
   output logic [31:0]         o_test_value,
   output logic [TIME_W-1:0]   o_vita_time,
   output rb_sel_e             o_rb_sel
);

   logic                loopback;
   logic [31:0]         test_r;
   logic [SAMPLE_W-1:0] codec_idle;
   rb_sel_e             rb_sel_r;
   logic [31:0]         time_hi;
   logic [TIME_W-1:0]   vita_time;

   ////////////////////
   // Setting registers

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         loopback   <= 1'b0;
         test_r     <= '0;
         codec_idle <= IDLE_DEFAULT;
         rb_sel_r   <= RB_TEST;
         time_hi    <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_LOOPBACK:   loopback   <= i_set.data[0];
            SR_TEST:       test_r     <= i_set.data;
            SR_CODEC_IDLE: codec_idle <= i_set.data[SAMPLE_W-1:0];
            SR_READBACK:   rb_sel_r   <= rb_sel_e'(i_set.data[2:0]);
            SR_TIME_HI:    time_hi    <= i_set.data;  // Held until the low word lands
            default: ;
         endcase
      end
   end

   ////////////////////
   // Time counter

   // Loads as one 64-bit value on the low-word write
   always_ff @(posedge bus_clk) begin
      if (i_reset)
         vita_time <= '0;
      else if (i_set.stb && (i_set.addr == SR_TIME_LO))
         vita_time <= {time_hi, i_set.data};
      else
         vita_time <= vita_time + TIME_W'(1);
   end

   ////////////////////
   // Front end

   always_ff @(posedge bus_clk) begin
      o_tx    <= i_tx_run ? i_tx_sample : codec_idle;  // Idle pattern when not running
      o_rx_fe <= loopback ? o_tx : i_rx;               // Digital loopback TX to RX
   end

   assign o_test_value = test_r;
   assign o_vita_time  = vita_time;
   assign o_rb_sel     = rb_sel_r;

endmodule

// ==== readback_responder.sv ====
////////////////////
// Response sender. On each issue pulse it returns the command
// header, then the selected readback word with tlast set.
////////////////////

`timescale 1ns/1ns

module readback_responder
   import radio_pkg::*;
(
   input  logic                bus_clk,
   input  logic                i_reset,
   input  logic                i_issue,
   input  logic [63:0]         i_header,
   input  rb_sel_e             i_rb_sel,
   input  logic [31:0]         i_test_value,
   input  logic [TIME_W-1:0]   i_vita_time,
   input  logic [SAMPLE_W-1:0] i_tx_word,
   input  logic [SAMPLE_W-1:0] i_rx_fe,
   output stream_beat_t        o_resp,
   output logic                o_resp_tvalid,
   input  logic                i_resp_tready,
   output logic                o_resp_done
);

   logic        resp_valid;
   logic        word_beat;    // Second beat is on the bus
   logic [63:0] rb_word;
   logic [63:0] word_r;
   logic        resp_xfer;

   // Readback select
   always_comb begin
      case (i_rb_sel)
         RB_TEST:     rb_word = {32'd0, i_test_value};
         RB_TIME:     rb_word = i_vita_time;
         RB_FRONTEND: rb_word = {i_tx_word, i_rx_fe};
         default:     rb_word = 64'd0;
      endcase
   end

   assign resp_xfer = resp_valid && i_resp_tready;

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         resp_valid <= 1'b0;
         word_beat  <= 1'b0;
      end else if (i_issue) begin
         resp_valid <= 1'b1;
         word_beat  <= 1'b0;
      end else if (resp_xfer) begin
         resp_valid <= !word_beat;  // Done after the word beat
         word_beat  <= !word_beat;
      end
   end

   // Sample the word as the header leaves, then hold it under back-pressure
   always_ff @(posedge bus_clk) begin
      if (resp_xfer && !word_beat)
         word_r <= rb_word;
   end

   assign o_resp.tdata  = word_beat ? word_r : i_header;
   assign o_resp.tlast  = word_beat;
   assign o_resp_tvalid = resp_valid;
   assign o_resp_done   = resp_xfer && word_beat;

endmodule

// ==== radio_core.sv ====
////////////////////
// Radio control plane top level. Control packets decode into
// settings writes, each answered by a readback response.
////////////////////

`timescale 1ns/1ns

module radio_core
   import radio_pkg::*;
#(
   parameter logic [SAMPLE_W-1:0] IDLE_DEFAULT = '0
) (
   input  logic                bus_clk,
   input  logic                i_reset,
   input  stream_beat_t        i_ctrl,
   input  logic                i_ctrl_tvalid,
   output logic                o_ctrl_tready,
   output stream_beat_t        o_resp,
   output logic                o_resp_tvalid,
   input  logic                i_resp_tready,
   input  logic [SAMPLE_W-1:0] i_rx,
   input  logic                i_tx_run,
   input  logic [SAMPLE_W-1:0] i_tx_sample,
   output logic [SAMPLE_W-1:0] o_tx,
   output logic [SAMPLE_W-1:0] o_rx_fe
);

   set_bus_t          set_bus;
   logic [63:0]       header;
   logic              issue;
   logic              resp_done;
   logic [31:0]       test_value;
   logic [TIME_W-1:0] vita_time;
   rb_sel_e           rb_sel;

   ////////////////////
   // Decode, execute, respond

   ctrl_decoder ctrl_decoder0 (
      .bus_clk       (bus_clk),
      .i_reset       (i_reset),
      .i_ctrl        (i_ctrl),
      .i_ctrl_tvalid (i_ctrl_tvalid),
      .o_ctrl_tready (o_ctrl_tready),
      .o_set         (set_bus),
      .o_header      (header),
      .o_issue       (issue),
      .i_resp_done   (resp_done)
   );

   radio_settings #(.IDLE_DEFAULT(IDLE_DEFAULT)) radio_settings0 (
      .bus_clk      (bus_clk),
      .i_reset      (i_reset),
      .i_set        (set_bus),
      .i_rx         (i_rx),
      .i_tx_run     (i_tx_run),
      .i_tx_sample  (i_tx_sample),
      .o_tx         (o_tx),
      .o_rx_fe      (o_rx_fe),
      .o_test_value (test_value),
      .o_vita_time  (vita_time),
      .o_rb_sel     (rb_sel)
   );

   readback_responder readback_responder0 (
      .bus_clk       (bus_clk),
      .i_reset       (i_reset),
      .i_issue       (issue),
      .i_header      (header),
      .i_rb_sel      (rb_sel),
      .i_test_value  (test_value),
      .i_vita_time   (vita_time),
      .i_tx_word     (o_tx),      // TX front end feeds the readback too
      .i_rx_fe       (o_rx_fe),
      .o_resp        (o_resp),
      .o_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready),
      .o_resp_done   (resp_done)
   );

endmodule

// ==== radio_core_assertions.sv ====
////////////////////
// Stream and settings-bus checks, bound into radio_core.
////////////////////

`timescale 1ns/1ns

module radio_core_assertions
   import radio_pkg::*;
(
   input logic         bus_clk,
   input logic         i_reset,
   input stream_beat_t i_ctrl,
   input logic         i_ctrl_tvalid,
   input logic         i_ctrl_tready,
   input stream_beat_t i_resp,
   input logic         i_resp_tvalid,
   input logic         i_resp_tready,
   input set_bus_t     i_set
);

   // Senders hold valid and the beat until it transfers
   a_ctrl_hold: assert property (@(posedge bus_clk) disable iff (i_reset)
      i_ctrl_tvalid && !i_ctrl_tready |=> i_ctrl_tvalid && $stable(i_ctrl))
      else $error("ctrl beat dropped or changed while stalled");

   a_resp_hold: assert property (@(posedge bus_clk) disable iff (i_reset)
      i_resp_tvalid && !i_resp_tready |=> i_resp_tvalid && $stable(i_resp))
      else $error("response beat dropped or changed while stalled");

   a_stb_pulse: assert property (@(posedge bus_clk) disable iff (i_reset)
      i_set.stb |=> !i_set.stb)
      else $error("settings strobe high for more than one cycle");

   // Decoder takes no ctrl beat while a response is pending
   a_one_cmd: assert property (@(posedge bus_clk) disable iff (i_reset)
      i_resp_tvalid |-> !i_ctrl_tready)
      else $error("ctrl ready high while a response is pending");

endmodule

bind radio_core radio_core_assertions assertions0 (
   .bus_clk       (bus_clk),
   .i_reset       (i_reset),
   .i_ctrl        (i_ctrl),
   .i_ctrl_tvalid (i_ctrl_tvalid),
   .i_ctrl_tready (o_ctrl_tready),
   .i_resp        (o_resp),
   .i_resp_tvalid (o_resp_tvalid),
   .i_resp_tready (i_resp_tready),
   .i_set         (set_bus)
);

// ==== radio_core_tb.sv ====
////////////////////
// Testbench for radio_core. Runs a table of settings writes,
// checks each response packet and the front-end ports, with
// random back-pressure on the response stream.
////////////////////

`timescale 1ns/1ns

module radio_core_tb;
   import radio_pkg::*;

   localparam logic [31:0] IDLE_DEF = 32'hA5A5_5A5A;  // DUT idle pattern after reset
   localparam logic [31:0] IDLE     = 32'h0BAD_F00D;  // Idle pattern written later
   localparam logic [31:0] TXA      = 32'h7777_8888;
   localparam logic [31:0] TXB      = 32'h5555_6666;
   localparam logic [31:0] RXA      = 32'h3333_4444;
   localparam logic [31:0] TV1      = 32'hDEAD_BEEF;
   localparam logic [31:0] TV2      = 32'h1234_5678;
   localparam int          TIMEOUT  = 1000;           // Cycles per wait

   // One table row with command, front-end inputs and expected readback
   typedef struct packed {
      logic [7:0]  id;        // Low byte of the header
      sr_addr_e    addr;
      logic [31:0] data;
      logic        run;
      logic [31:0] tx;
      logic [31:0] rx;
      logic [63:0] exp_rb;
      logic        time_chk;  // Readback is a time with exp_rb as its lower bound
   } test_t;

   logic                bus_clk;
   logic                i_reset;
   stream_beat_t        i_ctrl;
   logic                i_ctrl_tvalid;
   logic                o_ctrl_tready;
   stream_beat_t        o_resp;
   logic                o_resp_tvalid;
   logic                i_resp_tready;
   logic [SAMPLE_W-1:0] i_rx;
   logic                i_tx_run;
   logic [SAMPLE_W-1:0] i_tx_sample;
   logic [SAMPLE_W-1:0] o_tx;
   logic [SAMPLE_W-1:0] o_rx_fe;

   test_t       tests[$];
   logic [31:0] lcg_state;
   int          checks;
   int          errors;

   radio_core #(.IDLE_DEFAULT(IDLE_DEF)) dut0 (
      .bus_clk       (bus_clk),
      .i_reset       (i_reset),
      .i_ctrl        (i_ctrl),
      .i_ctrl_tvalid (i_ctrl_tvalid),
      .o_ctrl_tready (o_ctrl_tready),
      .o_resp        (o_resp),
      .o_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready),
      .i_rx          (i_rx),
      .i_tx_run      (i_tx_run),
      .i_tx_sample   (i_tx_sample),
      .o_tx          (o_tx),
      .o_rx_fe       (o_rx_fe)
   );

   always #50 bus_clk = ~bus_clk;

   ////////////////////
   // Helpers

   // LCG drives ready about three cycles in four
   function automatic logic random_ready();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:29] != 2'b00;
   endfunction

   function automatic void add_test(input logic [7:0] id, input sr_addr_e addr,
                                    input logic [31:0] data, input logic run,
                                    input logic [31:0] tx, input logic [31:0] rx,
                                    input logic [63:0] exp_rb, input logic time_chk);
      test_t t;
      t = '{id, addr, data, run, tx, rx, exp_rb, time_chk};
      tests.push_back(t);
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
      end
   endtask

   // Holds the beat until the DUT takes it
   task automatic send_beat(input stream_beat_t beat, output bit ok);
      int n;
      @(posedge bus_clk);
      i_ctrl        <= beat;
      i_ctrl_tvalid <= 1'b1;
      @(negedge bus_clk);
      for (n = 0; n < TIMEOUT && !o_ctrl_tready; n++)
         @(negedge bus_clk);
      ok = o_ctrl_tready;
      @(posedge bus_clk);  // Beat transfers here
      i_ctrl_tvalid <= 1'b0;
   endtask

   // Returns at the negedge before the transfer edge
   task automatic recv_beat(output stream_beat_t beat, output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < TIMEOUT && !ok; n++) begin
         @(posedge bus_clk);
         i_resp_tready <= random_ready();
         @(negedge bus_clk);
         if (o_resp_tvalid && i_resp_tready) begin
            beat = o_resp;
            ok   = 1'b1;
         end
      end
   endtask

   ////////////////////
   // Stimulus table and run

   initial begin
      stream_beat_t beat0;
      stream_beat_t beat1;
      test_t        t;
      bit           ok;
      logic [31:0]  idle_m;
      logic         loop_m;
      logic [31:0]  exp_tx;
      logic [63:0]  hdr;
      logic [63:0]  want;
      int           n_err;
      int           i;

      bus_clk       = 1'b0;
      i_reset       = 1'b1;
      i_ctrl        = '0;
      i_ctrl_tvalid = 1'b0;
      i_resp_tready = 1'b0;
      i_rx          = '0;
      i_tx_run      = 1'b0;
      i_tx_sample   = '0;
      lcg_state     = 32'd78;
      checks        = 0;
      errors        = 0;
      idle_m        = IDLE_DEF;
      loop_m        = 1'b0;
      ok            = 1'b1;

      add_test(8'h01, SR_TEST,       TV1,            1'b0, TXA, RXA, {32'h0, TV1}, 1'b0);
      add_test(8'h02, SR_CODEC_IDLE, IDLE,           1'b0, TXA, RXA, {32'h0, TV1}, 1'b0);
      add_test(8'h03, SR_READBACK,   32'h3,          1'b0, TXA, RXA, {IDLE, RXA},  1'b0);
      add_test(8'h04, SR_TEST,       TV2,            1'b1, TXA, RXA, {TXA, RXA},   1'b0);
      add_test(8'h05, SR_READBACK,   32'h0,          1'b1, TXA, RXA, {32'h0, TV2}, 1'b0);
      add_test(8'h06, SR_LOOPBACK,   32'h1,          1'b1, TXB, RXA, {32'h0, TV2}, 1'b0);
      add_test(8'h07, SR_READBACK,   32'h3,          1'b1, TXB, RXA, {TXB, TXB},   1'b0);
      add_test(8'h08, SR_READBACK,   32'h3,          1'b0, TXB, RXA, {IDLE, IDLE}, 1'b0);
      add_test(8'h09, SR_READBACK,   32'h0,          1'b0, TXB, RXA, {32'h0, TV2}, 1'b0);
      add_test(8'h0A, SR_LOOPBACK,   32'h0,          1'b0, TXB, RXA, {32'h0, TV2}, 1'b0);
      add_test(8'h0B, SR_TIME_HI,    32'h1,          1'b0, TXB, RXA, {32'h0, TV2}, 1'b0);
      add_test(8'h0C, SR_TIME_LO,    32'h1000,       1'b0, TXB, RXA, {32'h0, TV2}, 1'b0);
      add_test(8'h0D, SR_READBACK,   32'h1,          1'b0, TXB, RXA, 64'h1_0000_1000, 1'b1);
      add_test(8'h0E, SR_READBACK,   32'h5,          1'b0, TXB, RXA, 64'h0, 1'b0);
      add_test(8'h0F, SR_TEST,       32'hAAAA_5555,  1'b0, TXB, RXA, 64'h0, 1'b0);
      add_test(8'h10, SR_READBACK,   32'h0,          1'b0, TXB, RXA, 64'hAAAA_5555, 1'b0);

      repeat (10) @(posedge bus_clk);
      i_reset <= 1'b0;
      repeat (3) @(posedge bus_clk);
      @(negedge bus_clk);
      check_value("o_ctrl_tready", 64'(o_ctrl_tready), 64'd1);
      check_value("o_resp_tvalid", 64'(o_resp_tvalid), 64'd0);
      check_value("o_tx", 64'(o_tx), 64'(IDLE_DEF));

      for (i = 0; i < tests.size() && ok; i++) begin
         t     = tests[i];
         n_err = errors;
         hdr   = {56'hC0DE_0000_0000_00, t.id};
         @(posedge bus_clk);
         i_tx_run    <= t.run;
         i_tx_sample <= t.tx;
         i_rx        <= t.rx;
         repeat (4) @(posedge bus_clk);  // Let the front end settle
         send_beat({hdr, 1'b0}, ok);
         if (ok) send_beat({{24'h0, t.addr, t.data}, 1'b1}, ok);
         if (ok) recv_beat(beat0, ok);
         if (ok) recv_beat(beat1, ok);
         if (!ok) begin
            errors++;
            $display("Test %0d timed out waiting for a stream handshake", i);
         end else begin
            if (t.addr == SR_CODEC_IDLE) idle_m = t.data;
            if (t.addr == SR_LOOPBACK) loop_m = t.data[0];
            want = t.exp_rb;
            // Counter keeps running so anything under 100 cycles later is accepted
            if (t.time_chk && beat1.tdata >= t.exp_rb && beat1.tdata < t.exp_rb + 64'd100)
               want = beat1.tdata;
            check_value("o_resp.tdata header", beat0.tdata, hdr);
            check_value("o_resp.tlast header", 64'(beat0.tlast), 64'd0);
            check_value("o_resp.tdata readback", beat1.tdata, want);
            check_value("o_resp.tlast readback", 64'(beat1.tlast), 64'd1);
            repeat (4) @(posedge bus_clk);
            @(negedge bus_clk);
            exp_tx = t.run ? t.tx : idle_m;
            check_value("o_tx", 64'(o_tx), 64'(exp_tx));
            check_value("o_rx_fe", 64'(o_rx_fe), 64'(loop_m ? exp_tx : t.rx));
            check_value("o_resp_tvalid", 64'(o_resp_tvalid), 64'd0);  // One response only
            check_value("o_ctrl_tready", 64'(o_ctrl_tready), 64'd1);
            if (errors == n_err)
               $display("Test %0d addr 0x%h: ok", i, t.addr);
            else
               $display("Test %0d addr 0x%h: mismatch", i, t.addr);
         end
      end

      $display("Tests run %0d, checks %0d, errors %0d", i, checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== project.f ====
radio_pkg.sv
ctrl_decoder.sv
radio_settings.sv
readback_responder.sv
radio_core.sv
radio_core_assertions.sv
radio_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the radio_core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module radio_core_tb
	-./obj_dir/Vradio_core_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation did not pass"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
